/* include/arb_defines.svh */
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// bus widths
`define ARB_ADDR_W 32
`define ARB_DATA_W 32
`define ARB_STRB_W 4
`define ARB_ID_W   4

// AR id per client, width matches ARB_ID_W
`define ARB_ID_IF  4'd0
`define ARB_ID_MEM 4'd1

// anything other than OKAY is an error
`define ARB_RESP_OKAY 2'b00

`endif

/* source/arb_ctrl_pkg.sv */
package arb_ctrl_pkg;

  // arbiter FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RD   = 2'd1,
    ST_WR   = 2'd2
  } arb_state_e;

  // what the latched command does on the bus
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // who owns the transaction
  typedef enum logic {
    CLI_IF  = 1'b0,
    CLI_MEM = 1'b1
  } client_e;

endpackage

/* source/arb_bus_pkg.sv */
`include "arb_defines.svh"

package arb_bus_pkg;
  import arb_ctrl_pkg::*;

  // client side
  typedef struct packed {
    logic                   valid;
    logic [`ARB_ADDR_W-1:0] addr;
  } if_req_t;

  typedef struct packed {
    logic                   ready; // one-cycle pulse
    logic [`ARB_DATA_W-1:0] rdata;
    logic                   err;
  } if_rsp_t;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`ARB_ADDR_W-1:0] addr;
    logic [`ARB_DATA_W-1:0] wdata;
    logic [`ARB_STRB_W-1:0] strb;
  } mem_req_t;

  typedef struct packed {
    logic                   ready;
    logic [`ARB_DATA_W-1:0] rdata;
    logic                   err;
  } mem_rsp_t;

  // AXI4 channels, single beat only
  typedef struct packed {
    logic                   valid;
    logic [`ARB_ADDR_W-1:0] addr;
    logic [`ARB_ID_W-1:0]   id;
  } axi_ar_t;

  typedef struct packed {
    logic                   valid;
    logic [`ARB_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axi_r_t;

  typedef struct packed {
    logic                   valid;
    logic [`ARB_ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic                   valid;
    logic [`ARB_DATA_W-1:0] data;
    logic [`ARB_STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axi_b_t;

  // command held for the whole transaction
  typedef struct packed {
    bus_op_e                op;
    client_e                owner;
    logic [`ARB_ADDR_W-1:0] addr;
    logic [`ARB_DATA_W-1:0] wdata;
    logic [`ARB_STRB_W-1:0] strb;
  } bus_cmd_t;

endpackage

/* source/arb_ctrl.sv */
`timescale 1ns/1ps

module arb_ctrl
  import arb_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       if_valid_i,
  input  logic       mem_valid_i,
  input  logic       mem_write_i,
  input  logic       rd_done_i,
  input  logic       wr_done_i,
  output client_e    grant_o,
  output logic       load_o,
  output logic       rd_start_o,
  output logic       wr_start_o,
  output arb_state_e state_o
);

  arb_state_e state_q;
  arb_state_e state_d;
  logic       start_q; // one cycle after the grant edge

  // memory client has fixed priority
  assign grant_o = mem_valid_i ? CLI_MEM : CLI_IF;

  // requests are only looked at while idle
  assign load_o = (state_q == ST_IDLE) & (if_valid_i | mem_valid_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (mem_valid_i && mem_write_i) begin
          state_d = ST_WR;
        end else if (mem_valid_i || if_valid_i) begin
          state_d = ST_RD;
        end
      end
      ST_RD: begin
        if (rd_done_i) begin
          state_d = ST_IDLE; // leaves with the ready pulse
        end
      end
      ST_WR: begin
        if (wr_done_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= load_o;
    end
  end

  // start goes to the channel picked at grant
  assign rd_start_o = start_q & (state_q == ST_RD);
  assign wr_start_o = start_q & (state_q == ST_WR);
  assign state_o    = state_q;

endmodule

/* source/req_path.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module req_path
  import arb_bus_pkg::*;
  import arb_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   load_i,
  input  client_e                grant_i,
  input  if_req_t                if_req_i,
  input  mem_req_t               mem_req_i,
  output bus_cmd_t               cmd_o,
  input  logic                   rd_done_i,
  input  logic [`ARB_DATA_W-1:0] rd_data_i,
  input  logic                   rd_err_i,
  input  logic                   wr_done_i,
  input  logic                   wr_err_i,
  output if_rsp_t                if_rsp_o,
  output mem_rsp_t               mem_rsp_o
);

  bus_op_e                op_q;
  client_e                owner_q;
  logic [`ARB_ADDR_W-1:0] addr_q;
  logic [`ARB_DATA_W-1:0] wdata_q;
  logic [`ARB_STRB_W-1:0] strb_q;
  logic                   done;
  logic                   err;

  // owner and operation decide the steering
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q    <= OP_READ;
      owner_q <= CLI_IF;
    end else if (load_i) begin
      owner_q <= grant_i;
      op_q    <= (grant_i == CLI_MEM && mem_req_i.write) ? OP_WRITE : OP_READ;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      addr_q  <= (grant_i == CLI_MEM) ? mem_req_i.addr : if_req_i.addr;
      wdata_q <= mem_req_i.wdata; // only used by writes
      strb_q  <= mem_req_i.strb;
    end
  end

  assign cmd_o = '{op: op_q, owner: owner_q, addr: addr_q, wdata: wdata_q, strb: strb_q};

  assign done = rd_done_i | wr_done_i;
  assign err  = (op_q == OP_WRITE) ? wr_err_i : rd_err_i;

  // only the owner sees ready
  always_comb begin
    if_rsp_o.ready  = done & (owner_q == CLI_IF);
    if_rsp_o.rdata  = rd_data_i;
    if_rsp_o.err    = err;
    mem_rsp_o.ready = done & (owner_q == CLI_MEM);
    mem_rsp_o.rdata = rd_data_i;
    mem_rsp_o.err   = err;
  end

endmodule

/* source/axi_rd_chan.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module axi_rd_chan
  import arb_bus_pkg::*;
  import arb_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   start_i,
  input  logic [`ARB_ADDR_W-1:0] addr_i,
  input  client_e                owner_i,
  output axi_ar_t                ar_o,
  input  logic                   arready_i,
  input  axi_r_t                 r_i,
  output logic                   rready_o,
  output logic                   done_o,
  output logic [`ARB_DATA_W-1:0] data_o,
  output logic                   err_o
);

  logic ar_pend_q; // AR still waiting for arready
  logic r_wait_q;
  logic ar_act;
  logic ar_hs;
  logic r_hs;

  // AR is up from the start cycle until accepted
  assign ar_act = start_i | ar_pend_q;
  assign ar_hs  = ar_act & arready_i;
  assign r_hs   = r_wait_q & r_i.valid;

  always_comb begin
    ar_o.valid = ar_act;
    ar_o.addr  = addr_i; // held stable by the command register
    ar_o.id    = (owner_i == CLI_MEM) ? `ARB_ID_MEM : `ARB_ID_IF;
  end

  assign rready_o = r_wait_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_pend_q <= 1'b0;
      r_wait_q  <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      ar_pend_q <= ar_act & ~arready_i;
      if (ar_hs) begin
        r_wait_q <= 1'b1;
      end else if (r_hs) begin
        r_wait_q <= 1'b0;
      end
      done_o <= r_hs; // one cycle after the R beat
    end
  end

  // read beat, valid together with done
  always_ff @(posedge clk) begin
    if (r_hs) begin
      data_o <= r_i.data;
      err_o  <= (r_i.resp != `ARB_RESP_OKAY);
    end
  end

endmodule

/* source/axi_wr_chan.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module axi_wr_chan
  import arb_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic                   start_i,
  input  logic [`ARB_ADDR_W-1:0] addr_i,
  input  logic [`ARB_DATA_W-1:0] data_i,
  input  logic [`ARB_STRB_W-1:0] strb_i,
  output axi_aw_t                aw_o,
  input  logic                   awready_i,
  output axi_w_t                 w_o,
  input  logic                   wready_i,
  input  axi_b_t                 b_i,
  output logic                   bready_o,
  output logic                   done_o,
  output logic                   err_o
);

  logic aw_pend_q;
  logic w_pend_q;
  logic b_wait_q;
  logic aw_act;
  logic w_act;
  logic aw_left;
  logic w_left;
  logic last_hs; // the later of the AW and W handshakes
  logic b_hs;

  // both rise on start, each falls on its own handshake
  assign aw_act  = start_i | aw_pend_q;
  assign w_act   = start_i | w_pend_q;
  assign aw_left = aw_act & ~awready_i;
  assign w_left  = w_act & ~wready_i;
  assign last_hs = (aw_act | w_act) & ~aw_left & ~w_left;
  assign b_hs    = b_wait_q & b_i.valid;

  always_comb begin
    aw_o.valid = aw_act;
    aw_o.addr  = addr_i;
    w_o.valid  = w_act;
    w_o.data   = data_i;
    w_o.strb   = strb_i;
  end

  assign bready_o = b_wait_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      b_wait_q  <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      aw_pend_q <= aw_left;
      w_pend_q  <= w_left;
      // bready only once address and data are both accepted
      if (last_hs) begin
        b_wait_q <= 1'b1;
      end else if (b_hs) begin
        b_wait_q <= 1'b0;
      end
      done_o <= b_hs;
    end
  end

  always_ff @(posedge clk) begin
    if (b_hs) begin
      err_o <= (b_i.resp != `ARB_RESP_OKAY);
    end
  end

endmodule

/* source/bus_arb_top.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module bus_arb_top
  import arb_bus_pkg::*;
  import arb_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  if_req_t  if_req_i,
  output if_rsp_t  if_rsp_o,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o,
  output axi_ar_t  ar_o,
  input  logic     arready_i,
  input  axi_r_t   r_i,
  output logic     rready_o,
  output axi_aw_t  aw_o,
  input  logic     awready_i,
  output axi_w_t   w_o,
  input  logic     wready_i,
  input  axi_b_t   b_i,
  output logic     bready_o
);

  client_e                grant;
  bus_cmd_t               cmd;
  logic                   load;
  logic                   rd_start;
  logic                   wr_start;
  logic                   rd_done;
  logic                   wr_done;
  logic [`ARB_DATA_W-1:0] rd_data;
  logic                   rd_err;
  logic                   wr_err;

  arb_ctrl arb_ctrl_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .if_valid_i (if_req_i.valid),
    .mem_valid_i(mem_req_i.valid),
    .mem_write_i(mem_req_i.write),
    .rd_done_i  (rd_done),
    .wr_done_i  (wr_done),
    .grant_o    (grant),
    .load_o     (load),
    .rd_start_o (rd_start),
    .wr_start_o (wr_start),
    .state_o    ()
  );

  req_path req_path_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (load),
    .grant_i  (grant),
    .if_req_i (if_req_i),
    .mem_req_i(mem_req_i),
    .cmd_o    (cmd),
    .rd_done_i(rd_done),
    .rd_data_i(rd_data),
    .rd_err_i (rd_err),
    .wr_done_i(wr_done),
    .wr_err_i (wr_err),
    .if_rsp_o (if_rsp_o),
    .mem_rsp_o(mem_rsp_o)
  );

  axi_rd_chan axi_rd_chan_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (rd_start),
    .addr_i   (cmd.addr),
    .owner_i  (cmd.owner),
    .ar_o     (ar_o),
    .arready_i(arready_i),
    .r_i      (r_i),
    .rready_o (rready_o),
    .done_o   (rd_done),
    .data_o   (rd_data),
    .err_o    (rd_err)
  );

  axi_wr_chan axi_wr_chan_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (wr_start),
    .addr_i   (cmd.addr),
    .data_i   (cmd.wdata),
    .strb_i   (cmd.strb),
    .aw_o     (aw_o),
    .awready_i(awready_i),
    .w_o      (w_o),
    .wready_i (wready_i),
    .b_i      (b_i),
    .bready_o (bready_o),
    .done_o   (wr_done),
    .err_o    (wr_err)
  );

endmodule

/* tests/bus_arb_asserts.sv */
`timescale 1ns/1ps

module bus_arb_asserts
  import arb_bus_pkg::*;
(
  input logic     clk,
  input logic     arst_n_i,
  input axi_ar_t  ar_i,
  input logic     arready_i,
  input axi_aw_t  aw_i,
  input axi_w_t   w_i,
  input if_req_t  if_req_i,
  input if_rsp_t  if_rsp_i,
  input mem_req_t mem_req_i,
  input mem_rsp_t mem_rsp_i
);

  // AR payload holds until accepted
  ar_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    ar_i.valid && !arready_i |=> ar_i.valid && $stable(ar_i.addr) && $stable(ar_i.id))
    else $error("AR valid or payload changed before arready");

  ar_aw_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(ar_i.valid && (aw_i.valid || w_i.valid)))
    else $error("AR active together with AW or W");

  if_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    if_rsp_i.ready |=> !if_rsp_i.ready)
    else $error("fetch ready longer than one cycle");

  mem_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    mem_rsp_i.ready |=> !mem_rsp_i.ready)
    else $error("memory ready longer than one cycle");

  if_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
    if_rsp_i.ready |-> if_req_i.valid)
    else $error("fetch ready without a fetch request");

  mem_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
    mem_rsp_i.ready |-> mem_req_i.valid)
    else $error("memory ready without a memory request");

endmodule

bind bus_arb_top bus_arb_asserts bus_arb_asserts_inst (
  .clk      (clk),
  .arst_n_i (arst_n_i),
  .ar_i     (ar_o),
  .arready_i(arready_i),
  .aw_i     (aw_o),
  .w_i      (w_o),
  .if_req_i (if_req_i),
  .if_rsp_i (if_rsp_o),
  .mem_req_i(mem_req_i),
  .mem_rsp_i(mem_rsp_o)
);

/* tests/bus_arb_tb.sv */
`timescale 1ns/1ps
`include "arb_defines.svh"

module bus_arb_tb
  import arb_bus_pkg::*;
();

  localparam logic [31:0] ERR_BASE = 32'h0000_0100; // first address past the 64-word memory
  localparam int          TIMEOUT  = 100;

  typedef struct packed {
    logic                   if_en;
    logic                   mem_en;
    logic                   mem_wr;
    logic [`ARB_ADDR_W-1:0] if_addr;
    logic [`ARB_ADDR_W-1:0] mem_addr;
    logic [`ARB_DATA_W-1:0] wdata;
    logic [`ARB_STRB_W-1:0] strb;
    logic [`ARB_DATA_W-1:0] if_exp;
    logic [`ARB_DATA_W-1:0] mem_exp;
    logic                   if_err;
    logic                   mem_err;
  } row_t;

  logic     clk;
  logic     arst_n;
  if_req_t  if_req;
  if_rsp_t  if_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  axi_ar_t  ar;
  axi_r_t   r = '0;
  axi_aw_t  aw;
  axi_w_t   w;
  axi_b_t   b = '0;
  logic     arready = 1'b0;
  logic     awready = 1'b0;
  logic     wready = 1'b0;
  logic     rready;
  logic     bready;

  logic [31:0] mem [0:63];
  logic [31:0] ref_mem [0:63]; // expected contents in table order
  logic [3:0]  ar_id_log [$];  // id of each accepted AR
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [31:0] w_data;
  logic [3:0]  w_strb;
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  b_wait;
  logic        r_pend;
  logic        aw_got;
  logic        w_got;
  logic        b_pend;
  int          seed = 32'h7988_d3f1;
  row_t        rows [$];
  int          id_seen = 0;
  int          checks = 0;
  int          errors = 0;
  logic        timed_out = 1'b0;

  bus_arb_top bus_arb_top_inst (
    .clk      (clk),
    .arst_n_i (arst_n),
    .if_req_i (if_req),
    .if_rsp_o (if_rsp),
    .mem_req_i(mem_req),
    .mem_rsp_o(mem_rsp),
    .ar_o     (ar),
    .arready_i(arready),
    .r_i      (r),
    .rready_o (rready),
    .aw_o     (aw),
    .awready_i(awready),
    .w_o      (w),
    .wready_i (wready),
    .b_i      (b),
    .bready_o (bready)
  );

  function automatic logic [1:0] pick_delay();
    logic [31:0] v;
    v = $random(seed);
    return v[1:0];
  endfunction

  // every word depends on its full byte address
  function automatic logic [31:0] fill_word(input logic [5:0] idx);
    logic [31:0] a;
    a = {24'd0, idx, 2'b00};
    return 32'h1357_9bdf ^ (a * 32'h0001_0001);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] wr_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) begin
        res[8*k +: 8] = wr_w[8*k +: 8];
      end
    end
    return res;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // AXI slave model with 0 to 3 cycles of extra delay per step
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      r       <= '0;
      b       <= '0;
      r_pend  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      b_pend  <= 1'b0;
      ar_wait <= pick_delay();
      aw_wait <= pick_delay();
      w_wait  <= pick_delay();
      for (int i = 0; i < 64; i++) begin
        mem[i] <= fill_word(i[5:0]);
      end
    end else begin
      if (arready) begin // AR handshake on this edge
        arready <= 1'b0;
        ar_wait <= pick_delay();
        rd_addr <= ar.addr;
        ar_id_log.push_back(ar.id);
        r_pend  <= 1'b1;
        r_wait  <= pick_delay();
      end else if (ar.valid) begin
        if (ar_wait == 2'd0) arready <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      if (r_pend) begin
        if (r_wait == 2'd0) begin
          r.valid <= 1'b1;
          r.data  <= (rd_addr >= ERR_BASE) ? 32'h0 : mem[rd_addr[7:2]];
          r.resp  <= (rd_addr >= ERR_BASE) ? 2'b10 : `ARB_RESP_OKAY;
          r_pend  <= 1'b0;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end else if (r.valid && rready) begin
        r.valid <= 1'b0;
      end
      if (awready) begin
        awready <= 1'b0;
        aw_wait <= pick_delay();
        wr_addr <= aw.addr;
        aw_got  <= 1'b1;
      end else if (aw.valid) begin
        if (aw_wait == 2'd0) awready <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end
      if (wready) begin
        wready <= 1'b0;
        w_wait <= pick_delay();
        w_data <= w.data;
        w_strb <= w.strb;
        w_got  <= 1'b1;
      end else if (w.valid) begin
        if (w_wait == 2'd0) wready <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end
      if (aw_got && w_got) begin // commit once both halves are in
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        if (wr_addr < ERR_BASE) begin
          mem[wr_addr[7:2]] <= merge_bytes(mem[wr_addr[7:2]], w_data, w_strb);
        end
        b_pend <= 1'b1;
        b_wait <= pick_delay();
      end
      if (b_pend) begin
        if (b_wait == 2'd0) begin
          b.valid <= 1'b1;
          b.resp  <= (wr_addr >= ERR_BASE) ? 2'b10 : `ARB_RESP_OKAY;
          b_pend  <= 1'b0;
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end else if (b.valid && bready) begin
        b.valid <= 1'b0;
      end
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // memory client goes first in a shared row
  task automatic add_row(input logic if_en, input logic [31:0] if_addr, input logic mem_en,
                         input logic mem_wr, input logic [31:0] mem_addr,
                         input logic [31:0] wdata, input logic [3:0] strb);
    row_t row;
    row          = '0;
    row.if_en    = if_en;
    row.if_addr  = if_addr;
    row.mem_en   = mem_en;
    row.mem_wr   = mem_wr;
    row.mem_addr = mem_addr;
    row.wdata    = wdata;
    row.strb     = strb;
    if (mem_en) begin
      row.mem_err = (mem_addr >= ERR_BASE);
      if (!row.mem_err && mem_wr) begin
        ref_mem[mem_addr[7:2]] = merge_bytes(ref_mem[mem_addr[7:2]], wdata, strb);
      end else if (!row.mem_err) begin
        row.mem_exp = ref_mem[mem_addr[7:2]];
      end
    end
    if (if_en) begin
      row.if_err = (if_addr >= ERR_BASE);
      if (!row.if_err) row.if_exp = ref_mem[if_addr[7:2]];
    end
    rows.push_back(row);
  endtask

  task automatic build_table();
    //      if    if_addr        mem   wr    mem_addr       wdata          strb
    add_row(1'b1, 32'h0000_0010, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    add_row(1'b1, 32'h0000_00f8, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    add_row(1'b0, 32'h0000_0000, 1'b1, 1'b1, 32'h0000_0020, 32'haabb_ccdd, 4'b0101);
    add_row(1'b0, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0020, 32'h0000_0000, 4'b0000);
    add_row(1'b1, 32'h0000_0008, 1'b1, 1'b0, 32'h0000_0030, 32'h0000_0000, 4'b0000);
    add_row(1'b1, 32'h0000_000c, 1'b1, 1'b1, 32'h0000_0034, 32'h1122_3344, 4'b1110);
    add_row(1'b0, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0034, 32'h0000_0000, 4'b0000);
    add_row(1'b0, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0100, 32'h0000_0000, 4'b0000);
    add_row(1'b0, 32'h0000_0000, 1'b1, 1'b1, 32'h0000_0104, 32'hcafe_f00d, 4'b1111);
    add_row(1'b1, 32'h0000_01f0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
    add_row(1'b1, 32'h0000_00fc, 1'b1, 1'b0, 32'h0000_0200, 32'h0000_0000, 4'b0000);
    add_row(1'b1, 32'h0000_003c, 1'b1, 1'b1, 32'h0000_003c, 32'h5566_7788, 4'b0011);
    add_row(1'b1, 32'h0000_0104, 1'b1, 1'b1, 32'h0000_0040, 32'h99aa_bbcc, 4'b1000);
    add_row(1'b1, 32'h0000_0040, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'b0000);
  endtask

  task automatic run_row(input row_t row, input int n);
    int          cyc;
    int          if_at;
    int          mem_at;
    int          errs_before;
    int          n_rd;
    logic        if_done;
    logic        mem_done;
    logic [31:0] if_data;
    logic [31:0] mem_data;
    logic        if_err;
    logic        mem_err;
    logic [3:0]  exp_ids [0:1];
    errs_before = errors;
    @(posedge clk);
    if_req  <= '{valid: row.if_en, addr: row.if_addr};
    mem_req <= '{valid: row.mem_en, write: row.mem_wr, addr: row.mem_addr,
                 wdata: row.wdata, strb: row.strb};
    if_done  = !row.if_en;
    mem_done = !row.mem_en;
    cyc      = 0;
    if_at    = 0;
    mem_at   = 0;
    while (!(if_done && mem_done) && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
      if (mem_rsp.ready) begin
        assert (!mem_done) else begin
          $display("row %0d: memory client got a ready it was not waiting for", n);
          errors++;
        end
        if (!mem_done) begin
          mem_req.valid <= 1'b0; // drop valid on the ready edge
          mem_done = 1'b1;
          mem_at   = cyc;
          mem_data = mem_rsp.rdata;
          mem_err  = mem_rsp.err;
        end
      end
      if (if_rsp.ready) begin
        assert (!if_done) else begin
          $display("row %0d: fetch client got a ready it was not waiting for", n);
          errors++;
        end
        if (!if_done) begin
          if_req.valid <= 1'b0;
          if_done = 1'b1;
          if_at   = cyc;
          if_data = if_rsp.rdata;
          if_err  = if_rsp.err;
        end
      end
    end
    if (!(if_done && mem_done)) begin
      $display("row %0d: timeout, no client ready within %0d cycles", n, TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    n_rd = 0;
    if (row.mem_en) begin
      check_bit("mem_rsp.err", mem_err, row.mem_err);
      if (!row.mem_wr && !row.mem_err) check_word("mem_rsp.rdata", mem_data, row.mem_exp);
      if (!row.mem_wr) begin
        exp_ids[n_rd] = `ARB_ID_MEM;
        n_rd++;
      end
    end
    if (row.if_en) begin
      check_bit("if_rsp.err", if_err, row.if_err);
      if (!row.if_err) check_word("if_rsp.rdata", if_data, row.if_exp);
      exp_ids[n_rd] = `ARB_ID_IF;
      n_rd++;
    end
    if (row.if_en && row.mem_en) begin
      assert (mem_at < if_at) else begin
        $display("row %0d: memory ready (cycle %0d) did not come before fetch ready (cycle %0d)",
                 n, mem_at, if_at);
        errors++;
      end
    end
    check_word("accepted AR count", ar_id_log.size(), id_seen + n_rd);
    for (int k = 0; k < n_rd; k++) begin
      if (id_seen + k < ar_id_log.size()) begin
        check_word("ar.id", {28'd0, ar_id_log[id_seen + k]}, {28'd0, exp_ids[k]});
      end
    end
    id_seen = ar_id_log.size();
    $display("row %0d: %s", n, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    arst_n  = 1'b0;
    if_req  = '0;
    mem_req = '0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = fill_word(i[5:0]);
    end
    build_table();
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_bit("if_rsp.ready", if_rsp.ready, 1'b0);
    check_bit("mem_rsp.ready", mem_rsp.ready, 1'b0);
    check_bit("ar.valid", ar.valid, 1'b0);
    check_bit("aw.valid", aw.valid, 1'b0);
    check_bit("w.valid", w.valid, 1'b0);
    check_bit("rready", rready, 1'b0);
    check_bit("bready", bready, 1'b0);
    $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
    for (int n = 0; n < rows.size() && !timed_out; n++) begin
      run_row(rows[n], n);
    end
    $display("%0d rows, %0d checks, %0d failed", rows.size(), checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
source/arb_ctrl_pkg.sv
source/arb_bus_pkg.sv
source/arb_ctrl.sv
source/req_path.sv
source/axi_rd_chan.sv
source/axi_wr_chan.sv
source/bus_arb_top.sv
tests/bus_arb_asserts.sv
tests/bus_arb_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module bus_arb_tb -Mdir obj_dir -o bus_arb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/bus_arb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1
